// ==== gecko_pkg.sv ====
package gecko_pkg;

    localparam int NUM_REGS = 32;
    localparam int REG_STATUS_WIDTH = 3;
    localparam int JUMP_FLAG_WIDTH = 2;

    typedef logic [31:0] instruction_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] reg_value_t;
    typedef logic [REG_STATUS_WIDTH-1:0] reg_status_t;
    typedef logic [JUMP_FLAG_WIDTH-1:0] jump_flag_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [7:0] exit_code_t;
    typedef logic [31:0] retired_count_t;

    // a0 holds the exit code for ecall/ebreak
    localparam reg_addr_t REG_A0 = 5'd10;

    // RV32I major opcodes
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_SYSTEM = 7'b1110011;

    // ecall and ebreak share this funct3
    localparam funct3_t FUNCT3_SYS_ENV = 3'b000;

    typedef enum logic [1:0] {
        DECODE_RESET,
        DECODE_NORMAL,
        DECODE_EXIT
    } decode_state_t;

    function automatic logic writes_rd(input opcode_t opcode);
        return opcode inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
                              OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP};
    endfunction

    function automatic logic uses_rs1(input opcode_t opcode);
        return opcode inside {OPCODE_JALR, OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE,
                              OPCODE_OP_IMM, OPCODE_OP};
    endfunction

    function automatic logic uses_rs2(input opcode_t opcode);
        return opcode inside {OPCODE_BRANCH, OPCODE_STORE, OPCODE_OP};
    endfunction

    function automatic logic is_control_flow(input opcode_t opcode);
        return opcode inside {OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH};
    endfunction

    function automatic logic is_legal(input opcode_t opcode);
        return opcode inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
                              OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE, OPCODE_OP_IMM,
                              OPCODE_OP, OPCODE_SYSTEM};
    endfunction

    function automatic reg_value_t decode_immediate(input instruction_t instr);
        reg_value_t imm;
        case (instr[6:0])
            OPCODE_LUI, OPCODE_AUIPC: imm = {instr[31:12], 12'b0};
            OPCODE_JAL: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            OPCODE_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OPCODE_STORE: imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            // I-type covers jalr, loads, op-imm and system
            default: imm = {{21{instr[31]}}, instr[30:20]};
        endcase
        return imm;
    endfunction

endpackage

// ==== gecko_register_file.sv ====
`timescale 1ns/1ns

module gecko_register_file (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  sweep_valid,
    input  gecko_pkg::reg_addr_t  sweep_addr,

    input  logic                  writeback_valid,
    input  gecko_pkg::reg_addr_t  writeback_addr,
    input  gecko_pkg::reg_value_t writeback_value,

    input  gecko_pkg::reg_addr_t  rs1_addr,
    input  gecko_pkg::reg_addr_t  rs2_addr,
    output gecko_pkg::reg_value_t rs1_value,
    output gecko_pkg::reg_value_t rs2_value
);

    gecko_pkg::reg_value_t regs [gecko_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        // the sweep zeroes one entry per cycle, x0 included
        if (sweep_valid) begin
            regs[sweep_addr] <= '0;
        end else if (writeback_valid && writeback_addr != '0) begin
            regs[writeback_addr] <= writeback_value;
        end
    end

    assign rs1_value = regs[rs1_addr];
    assign rs2_value = regs[rs2_addr];

    // nothing can be in flight while the file is being cleared
    sweep_writeback_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(sweep_valid && writeback_valid)
    );

endmodule

// ==== gecko_reg_scoreboard.sv ====
`timescale 1ns/1ns

module gecko_reg_scoreboard (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   sweep_valid,
    input  gecko_pkg::reg_addr_t   sweep_addr,

    input  logic                   writeback_valid,
    input  gecko_pkg::reg_addr_t   writeback_addr,

    input  logic                   issue_rd_valid,
    input  gecko_pkg::reg_addr_t   rs1_addr,
    input  gecko_pkg::reg_addr_t   rs2_addr,
    input  gecko_pkg::reg_addr_t   rd_addr,

    output logic                   rs1_ready,
    output logic                   rs2_ready,
    output logic                   rd_ready,
    output gecko_pkg::reg_status_t rd_status
);

    // front counts issued writes, rear counts retired writebacks
    gecko_pkg::reg_status_t front [gecko_pkg::NUM_REGS];
    gecko_pkg::reg_status_t rear [gecko_pkg::NUM_REGS];
    gecko_pkg::reg_status_t next_rd_status;

    always_ff @(posedge clk) begin
        if (sweep_valid) begin
            front[sweep_addr] <= '0;
            rear[sweep_addr] <= '0;
        end else begin
            if (issue_rd_valid && rd_addr != '0) begin
                front[rd_addr] <= next_rd_status;
            end
            if (writeback_valid && writeback_addr != '0) begin
                rear[writeback_addr] <= rear[writeback_addr] + 1'b1;
            end
        end
    end

    assign next_rd_status = front[rd_addr] + 1'b1;

    // equal counts mean no write is outstanding
    assign rs1_ready = (rs1_addr == '0) || (front[rs1_addr] == rear[rs1_addr]);
    assign rs2_ready = (rs2_addr == '0) || (front[rs2_addr] == rear[rs2_addr]);

    // counter full when one more issue would wrap onto rear
    assign rd_ready = next_rd_status != rear[rd_addr];
    assign rd_status = next_rd_status;

    // a writeback must belong to an issued write
    writeback_was_issued: assert property (
        @(posedge clk) disable iff (!arst_n)
        (writeback_valid && writeback_addr != '0) |->
            (front[writeback_addr] != rear[writeback_addr])
    );

endmodule

// ==== gecko_issue_control.sv ====
`timescale 1ns/1ns

module gecko_issue_control (
    input  logic                      clk,
    input  logic                      arst_n,

    input  logic                      instruction_data_valid,
    output logic                      instruction_data_ready,
    input  gecko_pkg::instruction_t   instruction_data,

    input  logic                      instruction_command_valid,
    output logic                      instruction_command_ready,
    input  gecko_pkg::reg_value_t     instruction_pc,
    input  gecko_pkg::jump_flag_t     instruction_jump_flag,

    input  logic                      jump_valid,
    input  logic                      jump_update_pc,

    output gecko_pkg::reg_addr_t      rs1_addr,
    output gecko_pkg::reg_addr_t      rs2_addr,
    output gecko_pkg::reg_addr_t      rd_addr,
    output logic                      issue_rd_valid,
    output logic                      sweep_valid,
    output gecko_pkg::reg_addr_t      sweep_addr,

    input  gecko_pkg::reg_value_t     rs1_value,
    input  gecko_pkg::reg_value_t     rs2_value,
    input  logic                      rs1_ready,
    input  logic                      rs2_ready,
    input  logic                      rd_ready,
    input  gecko_pkg::reg_status_t    rd_status,

    output logic                      execute_valid,
    input  logic                      execute_ready,
    output gecko_pkg::opcode_t        execute_opcode,
    output gecko_pkg::funct3_t        execute_funct3,
    output gecko_pkg::reg_addr_t      execute_rd,
    output gecko_pkg::reg_status_t    execute_rd_status,
    output gecko_pkg::reg_value_t     execute_rs1_value,
    output gecko_pkg::reg_value_t     execute_rs2_value,
    output gecko_pkg::reg_value_t     execute_imm,
    output gecko_pkg::reg_value_t     execute_pc,
    output logic                      execute_halt,

    output gecko_pkg::retired_count_t retired_instructions,
    output logic                      exit_flag,
    output gecko_pkg::exit_code_t     exit_code
);

    gecko_pkg::decode_state_t state;
    gecko_pkg::decode_state_t next_state;
    gecko_pkg::reg_addr_t sweep_counter;
    gecko_pkg::jump_flag_t jump_flag;
    logic branch_pending;

    gecko_pkg::opcode_t opcode;
    gecko_pkg::funct3_t funct3;
    logic is_env;
    logic halt_op;
    logic operands_ready;
    logic take;
    logic produce;
    logic stage_free;
    logic fire;
    logic issue;

    assign opcode = instruction_data[6:0];
    assign funct3 = instruction_data[14:12];
    assign is_env = (opcode == gecko_pkg::OPCODE_SYSTEM) && (funct3 == gecko_pkg::FUNCT3_SYS_ENV);
    assign halt_op = is_env || !gecko_pkg::is_legal(opcode);

    // ecall/ebreak read a0 for the exit code
    assign rs1_addr = is_env ? gecko_pkg::REG_A0 : instruction_data[19:15];
    assign rs2_addr = instruction_data[24:20];
    assign rd_addr = instruction_data[11:7];

    assign sweep_valid = state == gecko_pkg::DECODE_RESET;
    assign sweep_addr = sweep_counter;

    // halts need rs1 settled since it supplies the exit code
    assign operands_ready =
        (!(gecko_pkg::uses_rs1(opcode) || halt_op) || rs1_ready) &&
        (!gecko_pkg::uses_rs2(opcode) || rs2_ready) &&
        (!gecko_pkg::writes_rd(opcode) || rd_ready);

    always_comb begin
        take = 1'b0;
        produce = 1'b0;
        case (state)
            gecko_pkg::DECODE_NORMAL: begin
                if (instruction_jump_flag != jump_flag) begin
                    // misfetched, drop it
                    take = 1'b1;
                end else if (operands_ready && !branch_pending) begin
                    take = 1'b1;
                    produce = 1'b1;
                end
            end
            gecko_pkg::DECODE_EXIT: take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    // output register can take a command when empty or draining
    assign stage_free = !execute_valid || execute_ready;
    assign instruction_data_ready = take && stage_free;
    assign instruction_command_ready = take && stage_free;

    assign fire = instruction_data_valid && instruction_command_valid && instruction_data_ready;
    assign issue = fire && produce;
    assign issue_rd_valid = issue && gecko_pkg::writes_rd(opcode);

    assign exit_flag = state == gecko_pkg::DECODE_EXIT;

    always_comb begin
        next_state = state;
        case (state)
            gecko_pkg::DECODE_RESET: begin
                if (sweep_counter == gecko_pkg::reg_addr_t'(gecko_pkg::NUM_REGS - 1)) begin
                    next_state = gecko_pkg::DECODE_NORMAL;
                end
            end
            gecko_pkg::DECODE_NORMAL: begin
                if (issue && halt_op) begin
                    next_state = gecko_pkg::DECODE_EXIT;
                end
            end
            default: next_state = state;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= gecko_pkg::DECODE_RESET;
            sweep_counter <= '0;
            jump_flag <= '0;
            branch_pending <= 1'b0;
            retired_instructions <= '0;
            exit_code <= '0;
            execute_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (sweep_valid) begin
                sweep_counter <= sweep_counter + 1'b1;
            end
            // new epoch on every mispredict
            if (jump_valid && jump_update_pc) begin
                jump_flag <= jump_flag + 1'b1;
            end
            if (issue && gecko_pkg::is_control_flow(opcode)) begin
                branch_pending <= 1'b1;
            end else if (jump_valid) begin
                branch_pending <= 1'b0;
            end
            if (issue) begin
                retired_instructions <= retired_instructions + 1'b1;
            end
            if (issue && halt_op) begin
                exit_code <= rs1_value[7:0];
            end
            if (issue) begin
                execute_valid <= 1'b1;
            end else if (execute_ready) begin
                execute_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            execute_opcode <= opcode;
            execute_funct3 <= funct3;
            execute_rd <= rd_addr;
            execute_rd_status <= rd_status;
            execute_rs1_value <= rs1_value;
            execute_rs2_value <= rs2_value;
            execute_imm <= gecko_pkg::decode_immediate(instruction_data);
            execute_pc <= instruction_pc;
            execute_halt <= halt_op;
        end
    end

    // command must hold until execute takes it
    execute_payload_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (execute_valid && !execute_ready) |=> (execute_valid &&
            $stable({execute_opcode, execute_funct3, execute_rd, execute_rd_status,
                     execute_rs1_value, execute_rs2_value, execute_imm, execute_pc,
                     execute_halt}))
    );

endmodule

// ==== gecko_decode.sv ====
`timescale 1ns/1ns

module gecko_decode (
    input  logic                      clk,
    input  logic                      arst_n,

    input  logic                      instruction_data_valid,
    output logic                      instruction_data_ready,
    input  gecko_pkg::instruction_t   instruction_data,

    input  logic                      instruction_command_valid,
    output logic                      instruction_command_ready,
    input  gecko_pkg::reg_value_t     instruction_pc,
    input  gecko_pkg::jump_flag_t     instruction_jump_flag,

    input  logic                      jump_valid,
    input  logic                      jump_update_pc,

    input  logic                      writeback_valid,
    input  gecko_pkg::reg_addr_t      writeback_addr,
    input  gecko_pkg::reg_value_t     writeback_value,

    output logic                      execute_valid,
    input  logic                      execute_ready,
    output gecko_pkg::opcode_t        execute_opcode,
    output gecko_pkg::funct3_t        execute_funct3,
    output gecko_pkg::reg_addr_t      execute_rd,
    output gecko_pkg::reg_status_t    execute_rd_status,
    output gecko_pkg::reg_value_t     execute_rs1_value,
    output gecko_pkg::reg_value_t     execute_rs2_value,
    output gecko_pkg::reg_value_t     execute_imm,
    output gecko_pkg::reg_value_t     execute_pc,
    output logic                      execute_halt,

    output gecko_pkg::retired_count_t retired_instructions,
    output logic                      exit_flag,
    output gecko_pkg::exit_code_t     exit_code
);

    logic sweep_valid;
    gecko_pkg::reg_addr_t sweep_addr;
    gecko_pkg::reg_addr_t rs1_addr;
    gecko_pkg::reg_addr_t rs2_addr;
    gecko_pkg::reg_addr_t rd_addr;
    logic issue_rd_valid;
    gecko_pkg::reg_value_t rs1_value;
    gecko_pkg::reg_value_t rs2_value;
    logic rs1_ready;
    logic rs2_ready;
    logic rd_ready;
    gecko_pkg::reg_status_t rd_status;

    gecko_register_file register_file_i (
        .clk, .arst_n,
        .sweep_valid, .sweep_addr,
        .writeback_valid, .writeback_addr, .writeback_value,
        .rs1_addr, .rs2_addr,
        .rs1_value, .rs2_value
    );

    // status tables see the same writeback pulse as the register file
    gecko_reg_scoreboard reg_scoreboard_i (
        .clk, .arst_n,
        .sweep_valid, .sweep_addr,
        .writeback_valid, .writeback_addr,
        .issue_rd_valid,
        .rs1_addr, .rs2_addr, .rd_addr,
        .rs1_ready, .rs2_ready, .rd_ready,
        .rd_status
    );

    gecko_issue_control issue_control_i (
        .clk, .arst_n,
        .instruction_data_valid, .instruction_data_ready, .instruction_data,
        .instruction_command_valid, .instruction_command_ready,
        .instruction_pc, .instruction_jump_flag,
        .jump_valid, .jump_update_pc,
        .rs1_addr, .rs2_addr, .rd_addr, .issue_rd_valid,
        .sweep_valid, .sweep_addr,
        .rs1_value, .rs2_value,
        .rs1_ready, .rs2_ready, .rd_ready, .rd_status,
        .execute_valid, .execute_ready,
        .execute_opcode, .execute_funct3, .execute_rd, .execute_rd_status,
        .execute_rs1_value, .execute_rs2_value, .execute_imm, .execute_pc,
        .execute_halt,
        .retired_instructions, .exit_flag, .exit_code
    );

endmodule

// ==== tb_gecko_decode.sv ====
`timescale 1ns/1ns

module tb_gecko_decode;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [2:0]  rd_status;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        halt;
    } command_t;

    logic clk = 1'b0;
    logic arst_n;
    logic instruction_data_valid;
    logic instruction_data_ready;
    gecko_pkg::instruction_t instruction_data;
    logic instruction_command_valid;
    logic instruction_command_ready;
    gecko_pkg::reg_value_t instruction_pc;
    gecko_pkg::jump_flag_t instruction_jump_flag;
    logic jump_valid;
    logic jump_update_pc;
    logic writeback_valid;
    gecko_pkg::reg_addr_t writeback_addr;
    gecko_pkg::reg_value_t writeback_value;
    logic execute_valid;
    logic execute_ready;
    gecko_pkg::opcode_t execute_opcode;
    gecko_pkg::funct3_t execute_funct3;
    gecko_pkg::reg_addr_t execute_rd;
    gecko_pkg::reg_status_t execute_rd_status;
    gecko_pkg::reg_value_t execute_rs1_value;
    gecko_pkg::reg_value_t execute_rs2_value;
    gecko_pkg::reg_value_t execute_imm;
    gecko_pkg::reg_value_t execute_pc;
    logic execute_halt;
    gecko_pkg::retired_count_t retired_instructions;
    logic exit_flag;
    gecko_pkg::exit_code_t exit_code;

    // reference model of register contents and status counters
    logic [31:0] model_regs [32];
    logic [2:0] model_front [32];
    logic [2:0] model_rear [32];
    gecko_pkg::jump_flag_t epoch;

    command_t accepted [$];
    command_t held_command;
    logic hold_pending = 1'b0;
    int cycle_count = 0;
    int unsigned seed;

    gecko_decode gecko_decode_i (.*);

    always #4 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else
            report_failure($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h",
                                     name, expected, actual));
    endtask

    // all tests together take roughly 350 cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 2000) begin
            report_failure("simulation did not finish within 2000 cycles");
        end
    end

    function automatic command_t snapshot_command();
        return {execute_opcode, execute_funct3, execute_rd, execute_rd_status,
                execute_rs1_value, execute_rs2_value, execute_imm, execute_pc,
                execute_halt};
    endfunction

    // records handshakes and watches payload stability under back-pressure
    always @(negedge clk) begin
        if (arst_n) begin
            if (hold_pending) begin
                assert (execute_valid && snapshot_command() === held_command) else
                    report_failure("execute command changed or vanished before acceptance");
            end
            hold_pending = execute_valid && !execute_ready;
            held_command = snapshot_command();
            if (execute_valid && execute_ready) begin
                accepted.push_back(snapshot_command());
            end
        end
    end

    function automatic logic [31:0] encode_add(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // bumps the model front counter and returns the status the DUT should attach
    function automatic logic [2:0] note_rd_issue(input logic [4:0] addr);
        model_front[addr] = model_front[addr] + 3'd1;
        return model_front[addr];
    endfunction

    function automatic logic source_ready(input logic [4:0] addr);
        return (addr == 5'd0) || (model_front[addr] == model_rear[addr]);
    endfunction

    task automatic present_instr(input logic [31:0] instr, input logic [31:0] pc,
                                 input gecko_pkg::jump_flag_t flag);
        @(posedge clk);
        instruction_data_valid <= 1'b1;
        instruction_command_valid <= 1'b1;
        instruction_data <= instr;
        instruction_pc <= pc;
        instruction_jump_flag <= flag;
    endtask

    task automatic finish_accept();
        @(negedge clk);
        while (!instruction_command_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        instruction_data_valid <= 1'b0;
        instruction_command_valid <= 1'b0;
    endtask

    task automatic send_instr(input logic [31:0] instr, input logic [31:0] pc,
                              input gecko_pkg::jump_flag_t flag);
        present_instr(instr, pc, flag);
        finish_accept();
    endtask

    task automatic drive_writeback(input logic [4:0] addr, input logic [31:0] value);
        @(posedge clk);
        writeback_valid <= 1'b1;
        writeback_addr <= addr;
        writeback_value <= value;
        @(posedge clk);
        writeback_valid <= 1'b0;
        model_regs[addr] = value;
        model_rear[addr] = model_rear[addr] + 3'd1;
    endtask

    task automatic pulse_jump(input logic mispredict);
        @(posedge clk);
        jump_valid <= 1'b1;
        jump_update_pc <= mispredict;
        @(posedge clk);
        jump_valid <= 1'b0;
    endtask

    task automatic wait_command(output command_t got);
        while (accepted.size() == 0) begin
            @(posedge clk);
        end
        got = accepted.pop_front();
    endtask

    task automatic apply_reset();
        int low_cycles;
        int r;
        @(posedge clk);
        arst_n <= 1'b0;
        for (r = 0; r < 32; r++) begin
            model_regs[r] = '0;
            model_front[r] = '0;
            model_rear[r] = '0;
        end
        epoch = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        low_cycles = 0;
        @(negedge clk);
        check_value("execute_valid", 0, execute_valid);
        check_value("exit_flag", 0, exit_flag);
        check_value("retired_instructions", 0, retired_instructions);
        check_value("exit_code", 0, exit_code);
        while (!instruction_command_ready) begin
            check_value("instruction_data_ready", 0, instruction_data_ready);
            low_cycles++;
            @(negedge clk);
        end
        check_value("instruction_command_ready low cycles", 32, low_cycles);
        check_value("instruction_data_ready", 1, instruction_data_ready);
    endtask

    task automatic reset_sweep();
        command_t got;
        logic [2:0] status;
        apply_reset();
        status = note_rd_issue(1);
        send_instr(encode_add(5'd1, 5'd2, 5'd3), 32'h0000_0000, epoch);
        wait_command(got);
        check_value("execute_rs1_value", model_regs[2], got.rs1_value);
        check_value("execute_rs2_value", model_regs[3], got.rs2_value);
        check_value("execute_rd_status", status, got.rd_status);
        drive_writeback(5'd1, $urandom);
    endtask

    task automatic writeback_hazard();
        command_t got;
        logic [2:0] status;
        status = note_rd_issue(5);
        send_instr(encode_addi(5'd5, 5'd0, 12'd7), 32'h0000_0010, epoch);
        wait_command(got);
        check_value("execute_rd", 5, got.rd);
        check_value("execute_rd_status", status, got.rd_status);
        check_value("execute_imm", 32'd7, got.imm);
        // x5 still pending so the add must wait
        status = note_rd_issue(6);
        present_instr(encode_add(5'd6, 5'd5, 5'd0), 32'h0000_0014, epoch);
        repeat (5) begin
            @(negedge clk);
            check_value("instruction_command_ready", source_ready(5), instruction_command_ready);
            check_value("commands while stalled", 0, accepted.size());
        end
        drive_writeback(5'd5, $urandom);
        finish_accept();
        wait_command(got);
        check_value("execute_rd", 6, got.rd);
        check_value("execute_rs1_value", model_regs[5], got.rs1_value);
        check_value("execute_rs2_value", 0, got.rs2_value);
        check_value("execute_rd_status", status, got.rd_status);
        drive_writeback(5'd6, $urandom);
    endtask

    task automatic back_pressure();
        command_t got;
        logic [11:0] imm_list [6];
        int i;
        accepted.delete();
        for (i = 0; i < 6; i++) begin
            imm_list[i] = $urandom;
        end
        fork
            begin
                for (i = 0; i < 6; i++) begin
                    send_instr(encode_addi(5'd0, 5'd0, imm_list[i]), 32'h100 + 4 * i, epoch);
                end
            end
            begin
                while (accepted.size() < 6) begin
                    @(posedge clk);
                    execute_ready <= $urandom_range(1, 0);
                end
                @(posedge clk);
                execute_ready <= 1'b1;
            end
        join
        repeat (3) @(posedge clk);
        check_value("accepted command count", 6, accepted.size());
        for (i = 0; i < 6; i++) begin
            wait_command(got);
            check_value("execute_pc", 32'h100 + 4 * i, got.pc);
            check_value("execute_imm", {{20{imm_list[i][11]}}, imm_list[i]}, got.imm);
        end
    endtask

    task automatic branch_and_epoch();
        command_t got;
        logic [31:0] retired_before;
        accepted.delete();
        @(negedge clk);
        retired_before = retired_instructions;
        // bne x0, x0
        send_instr(32'h0000_1063, 32'h200, epoch);
        wait_command(got);
        check_value("execute_opcode", 7'h63, got.opcode);
        check_value("execute_funct3", 3'b001, got.funct3);
        present_instr(encode_addi(5'd0, 5'd0, 12'd1), 32'h204, epoch);
        repeat (4) begin
            @(negedge clk);
            check_value("instruction_command_ready", 0, instruction_command_ready);
        end
        pulse_jump(1'b0);
        finish_accept();
        wait_command(got);
        check_value("execute_pc", 32'h204, got.pc);
        send_instr(32'h0000_0063, 32'h208, epoch);
        wait_command(got);
        pulse_jump(1'b1);
        epoch = epoch + 1'b1;
        // fetched before the mispredict so these are dropped
        send_instr(encode_addi(5'd0, 5'd0, 12'd2), 32'h20c, epoch - 1'b1);
        send_instr(encode_addi(5'd0, 5'd0, 12'd3), 32'h210, epoch - 1'b1);
        repeat (3) @(posedge clk);
        check_value("commands from old epoch", 0, accepted.size());
        send_instr(encode_addi(5'd0, 5'd0, 12'd4), 32'h300, epoch);
        wait_command(got);
        check_value("execute_pc", 32'h300, got.pc);
        send_instr(encode_addi(5'd0, 5'd0, 12'd5), 32'h304, epoch);
        wait_command(got);
        check_value("execute_pc", 32'h304, got.pc);
        @(negedge clk);
        check_value("retired_instructions", retired_before + 5, retired_instructions);
    endtask

    task automatic exit_on_ecall();
        command_t got;
        logic [31:0] retired_before;
        logic [2:0] status;
        accepted.delete();
        status = note_rd_issue(10);
        send_instr(encode_addi(5'd10, 5'd0, 12'd0), 32'h400, epoch);
        wait_command(got);
        check_value("execute_rd", 10, got.rd);
        check_value("execute_rd_status", status, got.rd_status);
        drive_writeback(5'd10, 32'h2a);
        @(negedge clk);
        check_value("exit_flag", 0, exit_flag);
        send_instr(32'h0000_0073, 32'h404, epoch);
        wait_command(got);
        check_value("execute_halt", 1, got.halt);
        check_value("execute_rs1_value", model_regs[10], got.rs1_value);
        @(negedge clk);
        check_value("exit_flag", 1, exit_flag);
        check_value("exit_code", model_regs[10][7:0], exit_code);
        retired_before = retired_instructions;
        send_instr(encode_add(5'd3, 5'd1, 5'd2), 32'h408, epoch);
        send_instr(encode_addi(5'd4, 5'd0, 12'd5), 32'h40c, epoch + 1'b1);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("commands after exit", 0, accepted.size());
        check_value("retired_instructions", retired_before, retired_instructions);
    endtask

    task automatic illegal_opcode_halts();
        command_t got;
        accepted.delete();
        apply_reset();
        send_instr(32'h0000_007f, 32'h500, epoch);
        wait_command(got);
        check_value("execute_halt", 1, got.halt);
        check_value("execute_opcode", 7'h7f, got.opcode);
        @(negedge clk);
        check_value("exit_flag", 1, exit_flag);
        check_value("exit_code", model_regs[0][7:0], exit_code);
        check_value("retired_instructions", 1, retired_instructions);
    endtask

    initial begin
        seed = $urandom(32'hdeb0);
        arst_n = 1'b0;
        instruction_data_valid = 1'b0;
        instruction_command_valid = 1'b0;
        // idle word is a nop so ready reflects only the state
        instruction_data = 32'h0000_0013;
        instruction_pc = '0;
        instruction_jump_flag = '0;
        jump_valid = 1'b0;
        jump_update_pc = 1'b0;
        writeback_valid = 1'b0;
        writeback_addr = '0;
        writeback_value = '0;
        execute_ready = 1'b1;
        reset_sweep();
        writeback_hazard();
        back_pressure();
        branch_and_epoch();
        exit_on_ecall();
        illegal_opcode_halts();
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== sources.f ====
gecko_pkg.sv
gecko_register_file.sv
gecko_reg_scoreboard.sv
gecko_issue_control.sv
gecko_decode.sv
tb_gecko_decode.sv

// ==== Bender.yml ====
package:
  name: gecko_decode

sources:
  - gecko_pkg.sv
  - gecko_register_file.sv
  - gecko_reg_scoreboard.sv
  - gecko_issue_control.sv
  - gecko_decode.sv
  - target: simulation
    files:
      - tb_gecko_decode.sv
